/* filelist.f */
overlapPkg.sv
pipeIf.sv
shiftRegister.sv
pipelineManager.sv
overlapPipeline.sv
resultFifo.sv
overlapTop.sv
overlapTop_tb.sv

/* Makefile */
.PHONY: sim clean

LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module overlapTop_tb \
		-f filelist.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* overlapTop_tb.sv */
`timescale 1ns/1ps

module overlapTop_tb;
    import overlapPkg::*;

    localparam int PIPE_DEPTH = 3;
    localparam int INIT_CYCLES = 2;
    localparam int FIFO_DEPTH = 8;
    localparam int ROWS = 29;
    localparam int CYCLE_LIMIT = 40 * ROWS + 200;
    localparam int HOLD_LENGTH = 30;

    localparam logic [2:0] PAT_ONES = 3'd0;
    localparam logic [2:0] PAT_ZERO = 3'd1;
    localparam logic [2:0] PAT_ALT = 3'd2;
    localparam logic [2:0] PAT_ALT_INV = 3'd3;
    localparam logic [2:0] PAT_LFSR = 3'd4;

    localparam logic [1:0] READY_ALL = 2'd0;
    localparam logic [1:0] READY_HALF = 2'd1;
    localparam logic [1:0] READY_HOLD = 2'd2;
    localparam logic [1:0] READY_RANDOM = 2'd3;

    // Expected score taken from the running model instead of the table
    localparam score_t FROM_MODEL = 8'hFF;

    typedef struct packed {
        logic isTop;
        logic [2:0] pattern;
        logic [1:0] duty;
        score_t expected;
    } stimRow_t;

    // Columns are top or bot, data pattern, resultReady duty, expected score
    localparam stimRow_t STIM [ROWS] = '{
        '{1'b1, PAT_LFSR, READY_ALL, 8'd0},
        '{1'b0, PAT_ONES, READY_ALL, FROM_MODEL},
        '{1'b0, PAT_ONES, READY_HALF, FROM_MODEL},
        '{1'b1, PAT_ZERO, READY_ALL, 8'd0},
        '{1'b0, PAT_ONES, READY_ALL, 8'd0},
        '{1'b1, PAT_ONES, READY_ALL, 8'd0},
        '{1'b0, PAT_ONES, READY_ALL, 8'd128},
        '{1'b0, PAT_ALT, READY_HALF, 8'd64},
        '{1'b1, PAT_ALT, READY_ALL, 8'd0},
        '{1'b0, PAT_ALT, READY_ALL, 8'd64},
        '{1'b0, PAT_ALT_INV, READY_ALL, 8'd0},
        // Top change while the previous bots are still in flight
        '{1'b1, PAT_ONES, READY_ALL, 8'd0},
        '{1'b0, PAT_ALT_INV, READY_ALL, 8'd64},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_HOLD, FROM_MODEL},
        '{1'b1, PAT_LFSR, READY_RANDOM, 8'd0},
        '{1'b0, PAT_LFSR, READY_RANDOM, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_RANDOM, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_RANDOM, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_RANDOM, FROM_MODEL},
        '{1'b0, PAT_LFSR, READY_RANDOM, FROM_MODEL}
    };

    logic clk;
    logic rst;
    logic startNewTop;
    overlapWord_u topIn;
    overlapWord_u botIn;
    logic isBotInValid;
    logic readyForBotIn;
    logic resultReady;
    score_t result;
    logic resultValid;

    score_t expectedScores [$];
    overlapWord_u refTop;
    overlapWord_u nextWord;
    logic [31:0] lfsrState;
    logic sawStall;
    int holdCycles;
    int cycleCount;
    int scoreErrors;
    int flagErrors;
    int otherErrors;

    overlapTop #(
        .PIPE_DEPTH(PIPE_DEPTH),
        .INIT_CYCLES(INIT_CYCLES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) overlapTop_inst (
        .clk(clk),
        .rst(rst),
        .startNewTop(startNewTop),
        .topIn(topIn),
        .botIn(botIn),
        .isBotInValid(isBotInValid),
        .readyForBotIn(readyForBotIn),
        .resultReady(resultReady),
        .result(result),
        .resultValid(resultValid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
    function automatic logic lfsrBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic overlapWord_u makeWord(input logic [2:0] pattern);
        overlapWord_u word;
        case (pattern)
            PAT_ONES: word.flat = '1;
            PAT_ZERO: word.flat = '0;
            PAT_ALT: word.flat = {64{2'b10}};
            PAT_ALT_INV: word.flat = {64{2'b01}};
            default: begin
                for (int i = 0; i < WORD_WIDTH; i++) begin
                    word.flat[i] = lfsrBit();
                end
            end
        endcase
        return word;
    endfunction

    function automatic logic chooseReady(input logic [1:0] duty);
        case (duty)
            READY_HALF: return !resultReady;
            READY_HOLD: return holdCycles > HOLD_LENGTH;
            READY_RANDOM: return lfsrBit();
            default: return 1'b1;
        endcase
    endfunction

    task automatic checkScore(input score_t expected, input score_t actual);
        if (actual !== expected) begin
            scoreErrors++;
            $display("[ERROR] %0t: score expected %0d, got %0d", $time, expected, actual);
        end
    endtask

    task automatic compareFlag(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            flagErrors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    initial begin
        int row;
        logic offered;
        logic topJustTaken;
        logic [1:0] duty;
        clk = 1'b0;
        lfsrState = 32'd95416;
        refTop = '0;
        nextWord = '0;
        row = 0;
        offered = 1'b0;
        topJustTaken = 1'b0;
        sawStall = 1'b0;
        holdCycles = 0;
        scoreErrors = 0;
        flagErrors = 0;
        otherErrors = 0;
        rst <= 1'b1;
        startNewTop <= 1'b0;
        topIn <= '0;
        botIn <= '0;
        isBotInValid <= 1'b0;
        resultReady <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i > 0) begin
                compareFlag(1'b0, resultValid, "resultValid in reset");
            end
        end
        rst <= 1'b0;

        while (row < ROWS || expectedScores.size() != 0) begin
            @(posedge clk);
            duty = (row < ROWS) ? STIM[row].duty : READY_ALL;
            // DUT outputs still show the values from before this edge
            if (resultValid && resultReady) begin
                if (expectedScores.size() == 0) begin
                    otherErrors++;
                    $display("A score came out at %0t with no bot waiting for it", $time);
                end else begin
                    checkScore(expectedScores.pop_front(), result);
                end
            end
            if (topJustTaken) begin
                compareFlag(1'b0, readyForBotIn, "readyForBotIn with a top pending");
                topJustTaken = 1'b0;
            end
            if (duty == READY_HOLD) begin
                holdCycles++;
                if (!readyForBotIn) begin
                    sawStall = 1'b1;
                end
            end
            // A bot taken before the old bots drain would see the old top and miss its score
            if (isBotInValid && readyForBotIn) begin
                if (startNewTop) begin
                    refTop = nextWord;
                    topJustTaken = 1'b1;
                end else if (STIM[row].expected == FROM_MODEL) begin
                    expectedScores.push_back(score_t'($countones(refTop.flat & nextWord.flat)));
                end else begin
                    expectedScores.push_back(STIM[row].expected);
                end
                row++;
                offered = 1'b0;
            end
            if (row < ROWS && !offered) begin
                nextWord = makeWord(STIM[row].pattern);
                startNewTop <= STIM[row].isTop;
                topIn <= nextWord;
                botIn <= nextWord;
                isBotInValid <= 1'b1;
                offered = 1'b1;
            end else if (row >= ROWS) begin
                isBotInValid <= 1'b0;
                startNewTop <= 1'b0;
            end
            resultReady <= chooseReady(duty);
        end

        // No further score may appear once every expected one is out
        for (int i = 0; i < PIPE_DEPTH + 2; i++) begin
            @(posedge clk);
            compareFlag(1'b0, resultValid, "resultValid after the last score");
        end
        if (!sawStall) begin
            otherErrors++;
            $display("readyForBotIn never dropped while results were held back");
        end
        $display("Errors: %0d score, %0d flag, %0d other", scoreErrors, flagErrors, otherErrors);
        if (scoreErrors + flagErrors + otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* overlapTop.sv */
`timescale 1ns/1ps

module overlapTop #(
    parameter int PIPE_DEPTH = 3,
    parameter int INIT_CYCLES = 2,
    parameter int FIFO_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic startNewTop,
    input  overlapPkg::overlapWord_u topIn,
    input  overlapPkg::overlapWord_u botIn,
    input  logic isBotInValid,
    output logic readyForBotIn,
    input  logic resultReady,
    output overlapPkg::score_t result,
    output logic resultValid
);
    import overlapPkg::*;

    score_t pipeScore;
    logic scoreValid;
    logic fifoAlmostFull;
    logic fifoRead;

    pipeIf pipeBus ();

    pipelineManager #(
        .PIPE_DEPTH(PIPE_DEPTH),
        .INIT_CYCLES(INIT_CYCLES)
    ) pipelineManager_inst (
        .clk(clk),
        .rst(rst),
        .startNewTop(startNewTop),
        .topIn(topIn),
        .botIn(botIn),
        .isBotInValid(isBotInValid),
        .readyForBotIn(readyForBotIn),
        .resultValid(scoreValid),
        .fifoAlmostFull(fifoAlmostFull),
        .pipe(pipeBus.issue)
    );

    overlapPipeline overlapPipeline_inst (
        .clk(clk),
        .rst(rst),
        .pipe(pipeBus.score),
        .score(pipeScore)
    );

    // A score leaves only when the caller takes it
    assign fifoRead = resultValid && resultReady;

    resultFifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .PIPE_DEPTH(PIPE_DEPTH)
    ) resultFifo_inst (
        .clk(clk),
        .rst(rst),
        .writeEnable(scoreValid),
        .writeData(pipeScore),
        .readEnable(fifoRead),
        .readData(result),
        .notEmpty(resultValid),
        .almostFull(fifoAlmostFull)
    );

endmodule

/* resultFifo.sv */
`timescale 1ns/1ps

module resultFifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int PIPE_DEPTH = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic writeEnable,
    input  overlapPkg::score_t writeData,
    input  logic readEnable,
    output overlapPkg::score_t readData,
    output logic notEmpty,
    output logic almostFull
);
    import overlapPkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    // Leaves room for every score still in flight when the stall begins
    localparam int ALMOST_FULL_LEVEL = FIFO_DEPTH - PIPE_DEPTH - 1;

    score_t storage [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] readPtr;
    logic [PTR_WIDTH-1:0] writePtr;
    logic [COUNT_WIDTH-1:0] count;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= nextPtr(writePtr);
            end
            if (readEnable) begin
                readPtr <= nextPtr(readPtr);
            end
            case ({writeEnable, readEnable})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writePtr] <= writeData;
        end
    end

    // First-word fall-through, the oldest score is always on readData
    assign readData = storage[readPtr];
    assign notEmpty = count != '0;
    assign almostFull = count >= COUNT_WIDTH'(ALMOST_FULL_LEVEL);

    assert property (@(posedge clk) disable iff (rst)
        writeEnable |-> count != COUNT_WIDTH'(FIFO_DEPTH));

    assert property (@(posedge clk) disable iff (rst) readEnable |-> notEmpty);

endmodule

/* overlapPipeline.sv */
`timescale 1ns/1ps

module overlapPipeline (
    input  logic clk,
    input  logic rst,
    pipeIf.score pipe,
    output overlapPkg::score_t score
);
    import overlapPkg::*;

    localparam int LANE_BITS = $clog2(LANE_WIDTH + 1);
    localparam int PAIR_BITS = LANE_BITS + 1;
    localparam int PAIR_COUNT = LANE_COUNT / 2;

    overlapWord_u masked;
    logic [LANE_BITS-1:0] laneCount [LANE_COUNT];
    logic [PAIR_BITS-1:0] pairSum [PAIR_COUNT];
    score_t scoreSum;
    logic validS1;
    logic validS2;
    logic validS3;

    function automatic logic [LANE_BITS-1:0] countLane(input logic [LANE_WIDTH-1:0] lane);
        logic [LANE_BITS-1:0] total;
        total = '0;
        for (int i = 0; i < LANE_WIDTH; i++) begin
            total = total + LANE_BITS'(lane[i]);
        end
        return total;
    endfunction

    // Bits set in both words
    assign masked = overlapWord_u'(pipe.top.flat & pipe.bot.flat);

    always_comb begin
        scoreSum = '0;
        for (int p = 0; p < PAIR_COUNT; p++) begin
            scoreSum = scoreSum + score_t'(pairSum[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (pipe.advance) begin
            // Stage 1 counts each lane on its own
            for (int l = 0; l < LANE_COUNT; l++) begin
                laneCount[l] <= countLane(masked.lanes[l]);
            end
            // Stage 2 folds neighbouring lanes together
            for (int p = 0; p < PAIR_COUNT; p++) begin
                pairSum[p] <= PAIR_BITS'(laneCount[2*p]) + PAIR_BITS'(laneCount[2*p+1]);
            end
            score <= scoreSum;
        end
    end

    // Stage valids follow the same enable as the data
    always_ff @(posedge clk) begin
        if (rst) begin
            validS1 <= 1'b0;
            validS2 <= 1'b0;
            validS3 <= 1'b0;
        end else if (pipe.advance) begin
            validS1 <= pipe.botValid;
            validS2 <= validS1;
            validS3 <= validS2;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        validS3 |-> score <= score_t'(WORD_WIDTH));

endmodule

/* pipelineManager.sv */
`timescale 1ns/1ps

module pipelineManager #(
    parameter int PIPE_DEPTH = 3,
    parameter int INIT_CYCLES = 2
) (
    input  logic clk,
    input  logic rst,

    // From the caller
    input  logic startNewTop,
    input  overlapPkg::overlapWord_u topIn,
    input  overlapPkg::overlapWord_u botIn,
    input  logic isBotInValid,
    output logic readyForBotIn,

    // To and from the result FIFO
    output logic resultValid,
    input  logic fifoAlmostFull,

    // To the scoring pipeline
    pipeIf.issue pipe
);
    import overlapPkg::*;

    localparam int DRAIN_WIDTH = $clog2(PIPE_DEPTH + 1);
    localparam int INIT_WIDTH = $clog2(INIT_CYCLES + 2);

    overlapWord_u currentTop;
    overlapWord_u pendingTop;
    overlapWord_u botReg;
    logic pendingValid;
    logic botValidReg;
    logic [DRAIN_WIDTH-1:0] drainCount;
    logic [INIT_WIDTH-1:0] initCount;

    logic advance;
    logic initializing;
    logic botsCleared;
    logic takeWord;
    logic takeNewTop;
    logic takeBot;
    logic loadTop;
    logic lastSlotValid;

    assign initializing = initCount != '0;
    assign advance = !fifoAlmostFull && !initializing;
    assign readyForBotIn = advance && !pendingValid;

    // A word taken together with startNewTop is a top, never a bot
    assign takeWord = isBotInValid && readyForBotIn;
    assign takeNewTop = takeWord && startNewTop;
    assign takeBot = takeWord && !startNewTop;

    // Once PIPE_DEPTH advancing cycles pass with no new bot, nothing old is in flight
    assign botsCleared = drainCount == DRAIN_WIDTH'(PIPE_DEPTH);
    assign loadTop = pendingValid && botsCleared;

    always_ff @(posedge clk) begin
        if (rst) begin
            pendingValid <= 1'b0;
            botValidReg <= 1'b0;
            drainCount <= DRAIN_WIDTH'(PIPE_DEPTH);
            // Stay idle for a single cycle after reset
            initCount <= INIT_WIDTH'(1);
        end else begin
            if (loadTop) begin
                pendingValid <= 1'b0;
            end else if (takeNewTop) begin
                pendingValid <= 1'b1;
            end

            if (loadTop) begin
                initCount <= INIT_WIDTH'(INIT_CYCLES);
            end else if (initializing) begin
                initCount <= initCount - 1'b1;
            end

            if (advance) begin
                botValidReg <= takeBot;
                if (takeBot) begin
                    drainCount <= '0;
                end else if (!botsCleared) begin
                    drainCount <= drainCount + 1'b1;
                end
            end
        end
    end

    // Word payloads
    always_ff @(posedge clk) begin
        if (takeNewTop) begin
            pendingTop <= topIn;
        end
        if (loadTop) begin
            currentTop <= pendingTop;
        end
        if (advance) begin
            botReg <= botIn;
        end
    end

    assign pipe.top = currentTop;
    assign pipe.bot = botReg;
    assign pipe.botValid = botValidReg;
    assign pipe.advance = advance;

    // Marks which pipeline slots carry a real bot
    shiftRegister #(
        .CYCLES(PIPE_DEPTH),
        .WIDTH(1),
        .RESET_VALUE(1'b0)
    ) validSlots (
        .clk(clk),
        .rst(rst),
        .enable(advance),
        .din(botValidReg),
        .dout(lastSlotValid)
    );

    assign resultValid = lastSlotValid && advance;

    // A FIFO write must never happen while the pipeline is frozen
    assert property (@(posedge clk) disable iff (rst) resultValid |-> pipe.advance);

    assert property (@(posedge clk) disable iff (rst) pendingValid |-> !readyForBotIn);

endmodule

/* shiftRegister.sv */
`timescale 1ns/1ps

module shiftRegister #(
    parameter int CYCLES = 3,
    parameter int WIDTH = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stages [CYCLES];

    // The whole chain moves one step per enabled cycle and freezes otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else if (enable) begin
            stages[0] <= din;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[CYCLES-1];

endmodule

/* pipeIf.sv */
`timescale 1ns/1ps

interface pipeIf;
    import overlapPkg::*;

    // Reference word for every bot currently being issued
    overlapWord_u top;

    // Registered bot and its issue strobe
    overlapWord_u bot;
    logic botValid;

    // Shared stall enable, every pipeline stage holds while it is low
    logic advance;

    modport issue (output top, output bot, output botValid, output advance);

    modport score (input top, input bot, input botValid, input advance);

endinterface

/* overlapPkg.sv */
package overlapPkg;

    // Width of a top or a bot word
    localparam int WORD_WIDTH = 128;

    // A score runs from 0 to 128, so it needs eight bits
    localparam int SCORE_WIDTH = 8;

    // Lane split used for the partial counts in the first pipeline stage
    localparam int LANE_COUNT = 8;
    localparam int LANE_WIDTH = 16;

    // One word, read either flat or as sixteen-bit lanes
    typedef union packed {
        logic [WORD_WIDTH-1:0] flat;
        logic [LANE_COUNT-1:0][LANE_WIDTH-1:0] lanes;
    } overlapWord_u;

    typedef logic [SCORE_WIDTH-1:0] score_t;

endpackage
